// File: hdl/isa_pkg.sv
/*
 * RV32IM instruction set definitions: word layout, register index
 * and the opcode and funct codes recognised by the decoder
 */
`default_nettype none

package isa_pkg;

    typedef logic [4:0] arch_reg_idx_t;

    // R-type layout, the other formats reuse the same field positions
    typedef struct packed {
        logic [6:0]    funct7;
        arch_reg_idx_t rs2;
        arch_reg_idx_t rs1;
        logic [2:0]    funct3;
        arch_reg_idx_t rd;
        logic [6:0]    opcode;
    } inst_t;

    // major opcodes
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_auipc  = 7'b0010111;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_jalr   = 7'b1100111;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_store  = 7'b0100011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_system = 7'b1110011;

    localparam logic [2:0] f3_jalr = 3'b000;

    // conditional branches
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    // load and store sizes
    localparam logic [2:0] f3_lb  = 3'b000;
    localparam logic [2:0] f3_lh  = 3'b001;
    localparam logic [2:0] f3_lw  = 3'b010;
    localparam logic [2:0] f3_lbu = 3'b100;
    localparam logic [2:0] f3_lhu = 3'b101;
    localparam logic [2:0] f3_sb  = 3'b000;
    localparam logic [2:0] f3_sh  = 3'b001;
    localparam logic [2:0] f3_sw  = 3'b010;

    // integer ops, shared by register and immediate forms
    localparam logic [2:0] f3_add  = 3'b000;
    localparam logic [2:0] f3_sll  = 3'b001;
    localparam logic [2:0] f3_slt  = 3'b010;
    localparam logic [2:0] f3_sltu = 3'b011;
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_srl  = 3'b101;
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;

    // M extension, multiplies only
    localparam logic [2:0] f3_mul    = 3'b000;
    localparam logic [2:0] f3_mulh   = 3'b001;
    localparam logic [2:0] f3_mulhsu = 3'b010;
    localparam logic [2:0] f3_mulhu  = 3'b011;

    localparam logic [2:0] f3_csrrw = 3'b001;
    localparam logic [2:0] f3_csrrs = 3'b010;
    localparam logic [2:0] f3_csrrc = 3'b011;

    localparam logic [6:0] f7_base   = 7'b0000000;
    localparam logic [6:0] f7_alt    = 7'b0100000;
    localparam logic [6:0] f7_muldiv = 7'b0000001;

    // wfi is matched on the whole word
    localparam inst_t wfi_word = 32'h1050_0073;

endpackage

`default_nettype wire

// File: hdl/ctrl_pkg.sv
/*
 * Datapath control encodings produced by the decoder:
 * ALU function, operand sources and functional-unit class
 */
`default_nettype none

package ctrl_pkg;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_slt,
        alu_sltu,
        alu_and,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_sra
    } alu_func_t;

    typedef enum logic [1:0] {
        opa_is_rs1,
        opa_is_pc,
        opa_is_zero
    } opa_sel_t;

    // second operand, either rs2 or one of the immediate formats
    typedef enum logic [2:0] {
        opb_is_rs2,
        opb_is_i_imm,
        opb_is_s_imm,
        opb_is_b_imm,
        opb_is_u_imm,
        opb_is_j_imm
    } opb_sel_t;

    typedef enum logic [1:0] {
        fu_alu,
        fu_mult,
        fu_ldst,
        fu_bu
    } fu_type_t;

endpackage

`default_nettype wire

// File: hdl/inst_decoder.sv
/*
 * Instruction decoder, purely combinational. Maps an RV32IM word
 * to datapath control fields, unit class and register usage
 */
`timescale 1ns/1ps
`default_nettype none

module inst_decoder import isa_pkg::*, ctrl_pkg::*; #(
    parameter int PC_WIDTH = 32
) (
    input  inst_t                 inst,
    input  logic [PC_WIDTH-1:0]   pc,
    output logic [PC_WIDTH-1:0]   npc,
    output opa_sel_t              opa_select,
    output opb_sel_t              opb_select,
    output alu_func_t             alu_func,
    output fu_type_t              fu_type,
    output logic                  has_dest,
    output logic                  rd_mem,
    output logic                  wr_mem,
    output logic                  cond_branch,
    output logic                  uncond_branch,
    output logic                  mult,
    output logic                  csr_op,
    output logic                  halt,
    output logic                  illegal,
    output logic                  rs1_used,
    output logic                  rs2_used,
    output arch_reg_idx_t         rs1,
    output arch_reg_idx_t         rs2,
    output arch_reg_idx_t         rd
);

    always_comb begin
        // nop-like defaults
        opa_select    = opa_is_rs1;
        opb_select    = opb_is_rs2;
        alu_func      = alu_add;
        has_dest      = 1'b0;
        rd_mem        = 1'b0;
        wr_mem        = 1'b0;
        cond_branch   = 1'b0;
        uncond_branch = 1'b0;
        mult          = 1'b0;
        csr_op        = 1'b0;
        halt          = 1'b0;
        illegal       = 1'b0;

        case (inst.opcode)
            opc_lui: begin
                has_dest   = 1'b1;
                opa_select = opa_is_zero;
                opb_select = opb_is_u_imm;
            end
            opc_auipc: begin
                has_dest   = 1'b1;
                opa_select = opa_is_pc;
                opb_select = opb_is_u_imm;
            end
            opc_jal: begin
                has_dest      = 1'b1;
                opa_select    = opa_is_pc;
                opb_select    = opb_is_j_imm;
                uncond_branch = 1'b1;
            end
            opc_jalr: begin
                has_dest      = 1'b1;
                opb_select    = opb_is_i_imm;
                uncond_branch = 1'b1;
                illegal       = (inst.funct3 != f3_jalr);
            end
            opc_branch: begin
                opa_select  = opa_is_pc;
                opb_select  = opb_is_b_imm;
                cond_branch = 1'b1;
                case (inst.funct3)
                    f3_beq, f3_bne, f3_blt, f3_bge, f3_bltu, f3_bgeu: ;
                    default: illegal = 1'b1;
                endcase
            end
            opc_load: begin
                has_dest   = 1'b1;
                opb_select = opb_is_i_imm;
                rd_mem     = 1'b1;
                case (inst.funct3)
                    f3_lb, f3_lh, f3_lw, f3_lbu, f3_lhu: ;
                    default: illegal = 1'b1;
                endcase
            end
            opc_store: begin
                opb_select = opb_is_s_imm;
                wr_mem     = 1'b1;
                case (inst.funct3)
                    f3_sb, f3_sh, f3_sw: ;
                    default: illegal = 1'b1;
                endcase
            end
            opc_op_imm: begin
                has_dest   = 1'b1;
                opb_select = opb_is_i_imm;
                case (inst.funct3)
                    f3_add:  alu_func = alu_add;
                    f3_slt:  alu_func = alu_slt;
                    f3_sltu: alu_func = alu_sltu;
                    f3_xor:  alu_func = alu_xor;
                    f3_or:   alu_func = alu_or;
                    f3_and:  alu_func = alu_and;
                    f3_sll: begin
                        alu_func = alu_sll;
                        illegal  = (inst.funct7 != f7_base);
                    end
                    default: begin
                        // srli and srai share funct3, told apart by funct7
                        alu_func = (inst.funct7 == f7_alt) ? alu_sra : alu_srl;
                        illegal  = (inst.funct7 != f7_base) && (inst.funct7 != f7_alt);
                    end
                endcase
            end
            opc_op: begin
                has_dest = 1'b1;
                case (inst.funct7)
                    f7_base: begin
                        case (inst.funct3)
                            f3_add:  alu_func = alu_add;
                            f3_sll:  alu_func = alu_sll;
                            f3_slt:  alu_func = alu_slt;
                            f3_sltu: alu_func = alu_sltu;
                            f3_xor:  alu_func = alu_xor;
                            f3_srl:  alu_func = alu_srl;
                            f3_or:   alu_func = alu_or;
                            default: alu_func = alu_and;
                        endcase
                    end
                    f7_alt: begin
                        case (inst.funct3)
                            f3_add:  alu_func = alu_sub;
                            f3_srl:  alu_func = alu_sra;
                            default: illegal  = 1'b1;
                        endcase
                    end
                    f7_muldiv: begin
                        // divides are not supported by the mult unit
                        case (inst.funct3)
                            f3_mul, f3_mulh, f3_mulhsu, f3_mulhu: mult = 1'b1;
                            default: illegal = 1'b1;
                        endcase
                    end
                    default: illegal = 1'b1;
                endcase
            end
            opc_system: begin
                if (inst == wfi_word) begin
                    halt = 1'b1;
                end else begin
                    case (inst.funct3)
                        f3_csrrw, f3_csrrs, f3_csrrc: csr_op = 1'b1;
                        default: illegal = 1'b1;
                    endcase
                end
            end
            default: illegal = 1'b1;
        endcase

        // an illegal word goes down the pipe looking like a nop
        if (illegal) begin
            has_dest      = 1'b0;
            opa_select    = opa_is_rs1;
            opb_select    = opb_is_rs2;
            alu_func      = alu_add;
            rd_mem        = 1'b0;
            wr_mem        = 1'b0;
            cond_branch   = 1'b0;
            uncond_branch = 1'b0;
            mult          = 1'b0;
        end
    end

    assign npc = pc + PC_WIDTH'(4);

    assign rs1 = inst.rs1;
    assign rs2 = inst.rs2;
    assign rd  = inst.rd;

    assign rs1_used = cond_branch || (opa_select == opa_is_rs1);
    assign rs2_used = cond_branch || wr_mem || (opb_select == opb_is_rs2);

    // branch has priority, then memory, then multiply
    assign fu_type = (cond_branch || uncond_branch) ? fu_bu   :
                     (rd_mem || wr_mem)             ? fu_ldst :
                     mult                           ? fu_mult :
                                                      fu_alu;

endmodule

`default_nettype wire

// File: hdl/reg_scoreboard.sv
/*
 * Architectural register scoreboard: one busy bit per register,
 * set on dispatch and cleared on completion
 */
`timescale 1ns/1ps
`default_nettype none

module reg_scoreboard import isa_pkg::*; (
    input  logic          clock,
    input  logic          rst_n,
    input  arch_reg_idx_t rs1,
    input  arch_reg_idx_t rs2,
    output logic          rs1_busy,
    output logic          rs2_busy,
    input  logic          set_valid,
    input  arch_reg_idx_t set_reg,
    input  logic          complete_valid,
    input  arch_reg_idx_t complete_reg
);

    logic [31:0] busy_q;
    logic [31:0] busy_d;

    always_comb begin
        // x0 stays free, a set beats a clear of the same register
        busy_d[0] = 1'b0;
        for (int i = 1; i < 32; i++) begin
            if (set_valid && set_reg == arch_reg_idx_t'(i))
                busy_d[i] = 1'b1;
            else if (complete_valid && complete_reg == arch_reg_idx_t'(i))
                busy_d[i] = 1'b0;
            else
                busy_d[i] = busy_q[i];
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n)
            busy_q <= '0;
        else
            busy_q <= busy_d;
    end

    assign rs1_busy = busy_q[rs1];
    assign rs2_busy = busy_q[rs2];

endmodule

`default_nettype wire

// File: hdl/dispatch_stage.sv
/*
 * Dispatch stage: stalls on busy sources, marks the destination
 * busy, registers the dispatch record and latches WFI halt
 */
`timescale 1ns/1ps
`default_nettype none

module dispatch_stage import isa_pkg::*, ctrl_pkg::*; #(
    parameter int PC_WIDTH = 32
) (
    input  logic                clock,
    input  logic                rst_n,
    input  logic                inst_valid,
    input  logic [PC_WIDTH-1:0] pc,
    input  logic [PC_WIDTH-1:0] npc,
    input  opa_sel_t            opa_select,
    input  opb_sel_t            opb_select,
    input  alu_func_t           alu_func,
    input  fu_type_t            fu_type,
    input  logic                has_dest,
    input  arch_reg_idx_t       rd,
    input  logic                illegal,
    input  logic                halt,
    input  logic                rs1_used,
    input  logic                rs2_used,
    input  logic                rs1_busy,
    input  logic                rs2_busy,
    output logic                set_valid,
    output arch_reg_idx_t       set_reg,
    output logic                stall,
    output logic                dispatch_valid,
    output logic [PC_WIDTH-1:0] dispatch_pc,
    output logic [PC_WIDTH-1:0] dispatch_npc,
    output fu_type_t            dispatch_fu_type,
    output alu_func_t           dispatch_alu_func,
    output opa_sel_t            dispatch_opa_select,
    output opb_sel_t            dispatch_opb_select,
    output logic                dispatch_has_dest,
    output arch_reg_idx_t       dispatch_dest,
    output logic                dispatch_illegal,
    output logic                halted
);

    logic src_hazard;
    logic accept;

    assign src_hazard = (rs1_used && rs1_busy) || (rs2_used && rs2_busy);
    assign accept     = inst_valid && !halted && !src_hazard;
    assign stall      = inst_valid && !accept;

    assign set_valid = accept && has_dest;
    assign set_reg   = rd;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            dispatch_valid <= 1'b0;
            halted         <= 1'b0;
        end else begin
            dispatch_valid <= accept;
            // sticky until reset
            if (accept && halt)
                halted <= 1'b1;
        end
    end

    // record payload, only loaded on acceptance
    always_ff @(posedge clock) begin
        if (accept) begin
            dispatch_pc         <= pc;
            dispatch_npc        <= npc;
            dispatch_fu_type    <= fu_type;
            dispatch_alu_func   <= alu_func;
            dispatch_opa_select <= opa_select;
            dispatch_opb_select <= opb_select;
            dispatch_has_dest   <= has_dest;
            dispatch_dest       <= rd;
            dispatch_illegal    <= illegal;
        end
    end

endmodule

`default_nettype wire

// File: hdl/decode_dispatch_top.sv
/*
 * Decode and dispatch front end: decoder, scoreboard and dispatch stage
 */
`timescale 1ns/1ps
`default_nettype none

module decode_dispatch_top import isa_pkg::*, ctrl_pkg::*; #(
    parameter int PC_WIDTH = 32
) (
    input  logic                clock,
    input  logic                rst_n,
    input  logic                inst_valid,
    input  inst_t               inst,
    input  logic [PC_WIDTH-1:0] pc,
    input  logic                complete_valid,
    input  arch_reg_idx_t       complete_reg,
    output logic                stall,
    output logic                dispatch_valid,
    output logic [PC_WIDTH-1:0] dispatch_pc,
    output logic [PC_WIDTH-1:0] dispatch_npc,
    output fu_type_t            dispatch_fu_type,
    output alu_func_t           dispatch_alu_func,
    output opa_sel_t            dispatch_opa_select,
    output opb_sel_t            dispatch_opb_select,
    output logic                dispatch_has_dest,
    output arch_reg_idx_t       dispatch_dest,
    output logic                dispatch_illegal,
    output logic                halted
);

    logic [PC_WIDTH-1:0] npc;
    opa_sel_t            opa_select;
    opb_sel_t            opb_select;
    alu_func_t           alu_func;
    fu_type_t            fu_type;
    logic                has_dest;
    logic                illegal;
    logic                halt;
    logic                rs1_used;
    logic                rs2_used;
    arch_reg_idx_t       rs1;
    arch_reg_idx_t       rs2;
    arch_reg_idx_t       rd;
    logic                rs1_busy;
    logic                rs2_busy;
    logic                set_valid;
    arch_reg_idx_t       set_reg;

    // memory, branch and csr flags are only consumed inside the decoder here
    inst_decoder #(
        .PC_WIDTH(PC_WIDTH)
    ) u_decoder (
        .inst          (inst),
        .pc            (pc),
        .npc           (npc),
        .opa_select    (opa_select),
        .opb_select    (opb_select),
        .alu_func      (alu_func),
        .fu_type       (fu_type),
        .has_dest      (has_dest),
        .rd_mem        (),
        .wr_mem        (),
        .cond_branch   (),
        .uncond_branch (),
        .mult          (),
        .csr_op        (),
        .halt          (halt),
        .illegal       (illegal),
        .rs1_used      (rs1_used),
        .rs2_used      (rs2_used),
        .rs1           (rs1),
        .rs2           (rs2),
        .rd            (rd)
    );

    reg_scoreboard u_scoreboard (
        .clock          (clock),
        .rst_n          (rst_n),
        .rs1            (rs1),
        .rs2            (rs2),
        .rs1_busy       (rs1_busy),
        .rs2_busy       (rs2_busy),
        .set_valid      (set_valid),
        .set_reg        (set_reg),
        .complete_valid (complete_valid),
        .complete_reg   (complete_reg)
    );

    dispatch_stage #(
        .PC_WIDTH(PC_WIDTH)
    ) u_dispatch (
        .clock               (clock),
        .rst_n               (rst_n),
        .inst_valid          (inst_valid),
        .pc                  (pc),
        .npc                 (npc),
        .opa_select          (opa_select),
        .opb_select          (opb_select),
        .alu_func            (alu_func),
        .fu_type             (fu_type),
        .has_dest            (has_dest),
        .rd                  (rd),
        .illegal             (illegal),
        .halt                (halt),
        .rs1_used            (rs1_used),
        .rs2_used            (rs2_used),
        .rs1_busy            (rs1_busy),
        .rs2_busy            (rs2_busy),
        .set_valid           (set_valid),
        .set_reg             (set_reg),
        .stall               (stall),
        .dispatch_valid      (dispatch_valid),
        .dispatch_pc         (dispatch_pc),
        .dispatch_npc        (dispatch_npc),
        .dispatch_fu_type    (dispatch_fu_type),
        .dispatch_alu_func   (dispatch_alu_func),
        .dispatch_opa_select (dispatch_opa_select),
        .dispatch_opb_select (dispatch_opb_select),
        .dispatch_has_dest   (dispatch_has_dest),
        .dispatch_dest       (dispatch_dest),
        .dispatch_illegal    (dispatch_illegal),
        .halted              (halted)
    );

endmodule

`default_nettype wire

// File: verif/tb_decode_dispatch.sv
/*
 * Testbench for the decode and dispatch front end. Replays a cycle
 * trace into the DUT and checks stall and the dispatch record
 */
`timescale 1ns/1ps
`default_nettype none

module tb_decode_dispatch import isa_pkg::*, ctrl_pkg::*;;

    localparam int PC_WIDTH  = 32;
    localparam int MAX_LINES = 1000;

    logic                clock = 1'b0;
    logic                rst_n;
    logic                inst_valid;
    logic [31:0]         inst;
    logic [PC_WIDTH-1:0] pc;
    logic                complete_valid;
    logic [4:0]          complete_reg;
    logic                stall;
    logic                dispatch_valid;
    logic [PC_WIDTH-1:0] dispatch_pc;
    logic [PC_WIDTH-1:0] dispatch_npc;
    logic [1:0]          dispatch_fu_type;
    logic [3:0]          dispatch_alu_func;
    logic [1:0]          dispatch_opa_select;
    logic [2:0]          dispatch_opb_select;
    logic                dispatch_has_dest;
    logic [4:0]          dispatch_dest;
    logic                dispatch_illegal;
    logic                halted;

    // columns of the current trace line
    logic [31:0] in_valid, in_inst, in_pc, in_cvalid, in_creg;
    logic [31:0] exp_stall, exp_valid, exp_fu, exp_alu;
    logic [31:0] exp_dest_en, exp_dest, exp_illegal, exp_halted;

    // last instruction the stage took, due in the next record
    logic [PC_WIDTH-1:0] acc_pc;
    logic [31:0]         acc_inst;

    int    fd;
    int    code;
    int    line_no;
    int    cycles;
    string line;

    always #50 clock = ~clock;

    decode_dispatch_top #(
        .PC_WIDTH(PC_WIDTH)
    ) UUT (
        .clock               (clock),
        .rst_n               (rst_n),
        .inst_valid          (inst_valid),
        .inst                (inst),
        .pc                  (pc),
        .complete_valid      (complete_valid),
        .complete_reg        (complete_reg),
        .stall               (stall),
        .dispatch_valid      (dispatch_valid),
        .dispatch_pc         (dispatch_pc),
        .dispatch_npc        (dispatch_npc),
        .dispatch_fu_type    (dispatch_fu_type),
        .dispatch_alu_func   (dispatch_alu_func),
        .dispatch_opa_select (dispatch_opa_select),
        .dispatch_opb_select (dispatch_opb_select),
        .dispatch_has_dest   (dispatch_has_dest),
        .dispatch_dest       (dispatch_dest),
        .dispatch_illegal    (dispatch_illegal),
        .halted              (halted)
    );

    task automatic fail_and_stop;
        $display("tests failed");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic compare_value(input string what, input logic [31:0] actual,
                                 input logic [31:0] expected);
        if (actual !== expected) begin
            $display("mismatch at %0d ns: %s is %h, expected %h (trace line %0d)",
                     $time, what, actual, expected, line_no);
            fail_and_stop();
        end
    endtask

    // operand sources each instruction format needs, {opa, opb}
    function automatic logic [4:0] expected_selects(input logic [31:0] word,
                                                    input logic bad);
        opa_sel_t opa;
        opb_sel_t opb;
        opa = opa_is_rs1;
        opb = opb_is_rs2;
        if (!bad) begin
            case (word[6:0])
                opc_lui: begin
                    opa = opa_is_zero;
                    opb = opb_is_u_imm;
                end
                opc_auipc: begin
                    opa = opa_is_pc;
                    opb = opb_is_u_imm;
                end
                opc_jal: begin
                    opa = opa_is_pc;
                    opb = opb_is_j_imm;
                end
                opc_branch: begin
                    opa = opa_is_pc;
                    opb = opb_is_b_imm;
                end
                opc_jalr, opc_load, opc_op_imm: opb = opb_is_i_imm;
                opc_store: opb = opb_is_s_imm;
                default: ;
            endcase
        end
        return {opa, opb};
    endfunction

    task automatic check_outputs;
        logic [4:0] sel;
        compare_value("stall", 32'(stall), exp_stall);
        compare_value("dispatch_valid", 32'(dispatch_valid), exp_valid);
        compare_value("halted", 32'(halted), exp_halted);
        // the record payload only means something with a valid dispatch
        if (exp_valid[0]) begin
            sel = expected_selects(acc_inst, exp_illegal[0]);
            compare_value("dispatch_fu_type", 32'(dispatch_fu_type), exp_fu);
            compare_value("dispatch_alu_func", 32'(dispatch_alu_func), exp_alu);
            compare_value("dispatch_has_dest", 32'(dispatch_has_dest), exp_dest_en);
            compare_value("dispatch_dest", 32'(dispatch_dest), exp_dest);
            compare_value("dispatch_illegal", 32'(dispatch_illegal), exp_illegal);
            compare_value("dispatch_pc", 32'(dispatch_pc), 32'(acc_pc));
            compare_value("dispatch_npc", 32'(dispatch_npc), 32'(acc_pc + PC_WIDTH'(4)));
            compare_value("dispatch_opa_select", 32'(dispatch_opa_select), 32'(sel[4:3]));
            compare_value("dispatch_opb_select", 32'(dispatch_opb_select), 32'(sel[2:0]));
        end
    endtask

    initial begin
        rst_n          <= 1'b0;
        inst_valid     <= 1'b0;
        inst           <= '0;
        pc             <= '0;
        complete_valid <= 1'b0;
        complete_reg   <= '0;
        acc_pc   = '0;
        acc_inst = '0;
        line_no = 0;
        cycles  = 0;
        fd = $fopen("verif/decode_trace.txt", "r");
        if (fd == 0) begin
            $display("cannot open trace file verif/decode_trace.txt");
            fail_and_stop();
        end else begin
            repeat (3) @(posedge clock);
            rst_n <= 1'b1;
            // one data line per clock cycle, bounded by the line limit
            while (!$feof(fd) && line_no < MAX_LINES) begin
                code = $fgets(line, fd);
                line_no++;
                if (code != 0 && line.len() > 1 && line[0] != "#") begin
                    if ($sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
                                in_valid, in_inst, in_pc, in_cvalid, in_creg,
                                exp_stall, exp_valid, exp_fu, exp_alu,
                                exp_dest_en, exp_dest, exp_illegal, exp_halted) != 13) begin
                        $display("trace line %0d does not hold 13 hex columns", line_no);
                        fail_and_stop();
                    end else begin
                        @(posedge clock);
                        inst_valid     <= in_valid[0];
                        inst           <= in_inst;
                        pc             <= in_pc;
                        complete_valid <= in_cvalid[0];
                        complete_reg   <= in_creg[4:0];
                        // mid cycle, after the combinational stall has settled
                        @(negedge clock);
                        check_outputs();
                        // a valid word without stall is taken at the next edge
                        if (in_valid[0] && !exp_stall[0]) begin
                            acc_pc   = in_pc[PC_WIDTH-1:0];
                            acc_inst = in_inst;
                        end
                        cycles++;
                    end
                end
            end
            if (!$feof(fd)) begin
                $display("trace read gave up after %0d lines without reaching the end",
                         MAX_LINES);
                fail_and_stop();
            end else if (cycles == 0) begin
                $display("trace file holds no data lines");
                fail_and_stop();
            end else begin
                $fclose(fd);
                $display("all tests passed");
                $finish;
            end
        end
    end

endmodule

`default_nettype wire

// File: verif/decode_trace.txt
# inputs: inst_valid inst pc complete_valid complete_reg, all hex
# expected: stall dispatch_valid fu_type alu_func has_dest dest illegal halted
0 00000000 00000000 0 00  0 0 0 0 0 00 0 0
1 00500093 00001000 0 00  0 0 0 0 0 00 0 0
1 12345137 00001004 0 00  0 1 0 0 1 01 0 0
1 400001B3 00001008 0 00  0 1 0 0 1 02 0 0
1 00001217 0000100C 0 00  0 1 0 1 1 03 0 0
1 020002B3 00001010 0 00  0 1 0 0 1 04 0 0
1 40305693 00001014 0 00  0 1 1 0 1 05 0 0
1 00004733 00001018 0 00  0 1 0 9 1 0D 0 0
1 00002023 0000101C 0 00  0 1 0 6 1 0E 0 0
1 00402303 00001020 0 00  0 1 2 0 0 00 0 0
1 00000463 00001024 0 00  0 1 2 0 1 06 0 0
1 010003EF 00001028 0 00  0 1 3 0 0 08 0 0
1 FFFFFFFF 0000102C 1 05  0 1 3 0 1 07 0 0
# add x8 waits on x1 until its completion
1 00008433 00001030 0 00  1 1 0 0 0 1F 1 0
1 00008433 00001030 1 01  1 0 0 0 0 00 0 0
1 00008433 00001030 0 00  0 0 0 0 0 00 0 0
# set and clear of x9 in one cycle
1 00100493 00001034 1 09  0 1 0 0 1 08 0 0
1 00048533 00001038 0 00  1 1 0 0 1 09 0 0
1 00048533 00001038 1 09  1 0 0 0 0 00 0 0
1 00048533 00001038 0 00  0 0 0 0 0 00 0 0
1 10500073 0000103C 0 00  0 1 0 0 1 0A 0 0
1 00C00613 00001040 0 00  1 1 0 0 0 00 0 1
1 00C00613 00001040 0 00  1 0 0 0 0 00 0 1
0 00000000 00000000 0 00  0 0 0 0 0 00 0 1

// File: list.f
hdl/isa_pkg.sv
hdl/ctrl_pkg.sv
hdl/inst_decoder.sv
hdl/reg_scoreboard.sv
hdl/dispatch_stage.sv
hdl/decode_dispatch_top.sv
verif/tb_decode_dispatch.sv

// File: Makefile
VERILATOR  = verilator
LINT_FLAGS = --lint-only --timing
SIM_FLAGS  = --binary --timing
TOP        = tb_decode_dispatch
FILELIST   = list.f
PASS_MSG   = all tests passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir
